//--- hdl/qdec_pkg.sv
// ================================================
// Decode front end shared definitions
// Instruction word layout, opcodes, the registered
// decode bus and the fetch lane states
// ================================================

package qdec_pkg;

	// ================================================
	// Sizes
	// ================================================

	// Instruction memory is word addressed
	localparam int IMEM_AW    = 8;
	localparam int IMEM_DEPTH = 256;
	localparam int WORD_W     = 32;
	// Immediate width once a postfix word has extended it
	localparam int IMM_W      = 48;

	typedef logic [IMEM_AW-1:0] imem_addr_t;
	typedef logic [4:0]         reg_idx_t;

	// ================================================
	// Instruction word
	// ================================================

	// Register form, with rb and rc as operands
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t   rt;
		reg_idx_t   ra;
		reg_idx_t   rb;
		reg_idx_t   rc;
		logic [5:0] func;
	} instr_r_t;

	// Immediate form, where imm16 overlays rb, rc and func
	typedef struct packed {
		logic [5:0]  opcode;
		reg_idx_t    rt;
		reg_idx_t    ra;
		logic [15:0] imm16;
	} instr_i_t;

	// Postfix word; its payload carries immediate bits 41..16
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] payload;
	} instr_p_t;

	// All three views share the same 32 bits
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_p_t p;
	} instr_t;

	// Codes that are not listed here decode as an illegal nop
	typedef enum logic [5:0] {
		OP_NOP   = 6'd0,
		OP_ADD   = 6'd1,
		OP_SUB   = 6'd2,
		OP_ADDI  = 6'd3,
		OP_MUL   = 6'd4,
		OP_MULU  = 6'd5,
		OP_DIV   = 6'd6,
		OP_DIVU  = 6'd7,
		OP_LOAD  = 6'd8,
		OP_LOADZ = 6'd9,
		OP_STORE = 6'd10,
		OP_LDA   = 6'd11,
		OP_BEQ   = 6'd12,
		OP_BNE   = 6'd13,
		OP_FENCE = 6'd14,
		OP_PFX   = 6'd15,
		OP_HALT  = 6'd16
	} opcode_e;

	// ================================================
	// Decode bus
	// ================================================

	typedef struct packed {
		imem_addr_t       pc;
		opcode_e          opcode;
		reg_idx_t         rt;
		reg_idx_t         ra;
		reg_idx_t         rb;
		reg_idx_t         rc;
		logic [IMM_W-1:0] imm;
		logic             has_imm;
		logic             nop;
		logic             illegal;
		logic             alu;
		logic             mul;
		logic             mulu;
		logic             div;
		logic             divu;
		logic             load;
		logic             loadz;
		logic             store;
		logic             lda;
		logic             branch;
		logic             backbr;
		logic             fence;
		logic             pfx_used;
		logic             halt;
	} decode_bus_t;

	typedef enum logic [2:0] {
		IDLE,
		REQ0,
		WAIT0,
		REQ1,
		WAIT1,
		ISSUE,
		HALTED
	} lane_state_e;

endpackage

//--- hdl/imem_if.sv
// ================================================
// Instruction memory requester link
// One requester to the shared memory arbiter
// ================================================

interface imem_if;
	import qdec_pkg::*;

	// Request side, held until the grant is seen
	logic       req;
	imem_addr_t addr;

	// Grant for this cycle, read data one cycle later
	logic       gnt;
	instr_t     rdata;
	logic       rvalid;

	modport requester (
		output req,
		output addr,
		input  gnt,
		input  rdata,
		input  rvalid
	);

	modport arbiter (
		input  req,
		input  addr,
		output gnt,
		output rdata,
		output rvalid
	);

endinterface

//--- hdl/insn_mem.sv
// ================================================
// Instruction memory
// Single port synchronous RAM, one cycle read
// ================================================

module insn_mem (
	input  logic               clk,
	input  logic               en,
	input  logic               we,
	input  qdec_pkg::imem_addr_t addr,
	input  qdec_pkg::instr_t   wdata,
	output qdec_pkg::instr_t   rdata
);
	import qdec_pkg::*;

	// Word storage, loaded only through the write port
	logic [WORD_W-1:0] mem_array [IMEM_DEPTH];

	// One access per cycle, either a write or a read
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
			begin
				mem_array[addr] <= wdata;
			end
			else
			begin
				// Read data is registered and shows up the cycle after the grant
				rdata <= instr_t'(mem_array[addr]);
			end
		end
	end

endmodule

//--- hdl/imem_arbiter.sv
// ================================================
// Instruction memory arbiter
// Load port first, then round robin between lanes
// ================================================

module imem_arbiter (
	input  logic                 clk,
	input  logic                 reset,
	imem_if.arbiter              lane_a,
	imem_if.arbiter              lane_b,
	imem_if.arbiter              load,
	input  qdec_pkg::instr_t     wr_data,
	output logic                 mem_en,
	output logic                 mem_we,
	output qdec_pkg::imem_addr_t mem_addr,
	output qdec_pkg::instr_t     mem_wdata,
	input  qdec_pkg::instr_t     mem_rdata
);
	import qdec_pkg::*;

	logic gnt_load;
	logic gnt_a;
	logic gnt_b;
	// Set when lane B had the port most recently
	logic last_b;
	// Owner of the read that is in flight
	logic rd_a_q;
	logic rd_b_q;

	// ================================================
	// Grant selection
	// ================================================

	always_comb
	begin
		gnt_load = load.req;
		gnt_a    = 1'b0;
		gnt_b    = 1'b0;
		// Lanes only compete when no write is pending
		if (!load.req)
		begin
			if (lane_a.req && lane_b.req)
			begin
				// The lane that was not served last wins the tie
				gnt_a = last_b;
				gnt_b = !last_b;
			end
			else
			begin
				gnt_a = lane_a.req;
				gnt_b = lane_b.req;
			end
		end
	end

	assign load.gnt   = gnt_load;
	assign lane_a.gnt = gnt_a;
	assign lane_b.gnt = gnt_b;

	// Memory port follows whichever requester was granted
	assign mem_en    = gnt_load | gnt_a | gnt_b;
	assign mem_we    = gnt_load;
	assign mem_wdata = wr_data;
	assign mem_addr  = gnt_load ? load.addr : (gnt_b ? lane_b.addr : lane_a.addr);

	// ================================================
	// Fairness and read return
	// ================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Lane A gets the first tie after reset
			last_b <= 1'b1;
			rd_a_q <= 1'b0;
			rd_b_q <= 1'b0;
		end
		else
		begin
			rd_a_q <= gnt_a;
			rd_b_q <= gnt_b;
			if (gnt_a)
			begin
				last_b <= 1'b0;
			end
			else if (gnt_b)
			begin
				last_b <= 1'b1;
			end
		end
	end

	// The data bus is shared and only rvalid is steered
	assign lane_a.rdata  = mem_rdata;
	assign lane_a.rvalid = rd_a_q;
	assign lane_b.rdata  = mem_rdata;
	assign lane_b.rvalid = rd_b_q;
	// Writes never return data
	assign load.rdata    = mem_rdata;
	assign load.rvalid   = 1'b0;

	// At most one requester owns the port in any cycle
	a_gnt_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({load.gnt, lane_a.gnt, lane_b.gnt}));

	// Read data only returns to a lane whose address the memory read the cycle before
	a_rvalid_a: assert property (@(posedge clk) disable iff (reset)
		lane_a.rvalid |->
		$past(mem_en && !mem_we && lane_a.req && (mem_addr == lane_a.addr)));
	a_rvalid_b: assert property (@(posedge clk) disable iff (reset)
		lane_b.rvalid |->
		$past(mem_en && !mem_we && lane_b.req && (mem_addr == lane_b.addr)));

endmodule

//--- hdl/fetch_lane.sv
// ================================================
// Fetch lane
// Per thread pc and two word window sequencer
// ================================================

module fetch_lane (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   run,
	input  qdec_pkg::imem_addr_t   start_pc,
	imem_if.requester              mem,
	output logic                   window_valid,
	output qdec_pkg::imem_addr_t   window_pc,
	output qdec_pkg::instr_t [1:0] window,
	input  logic                   pfx_used
);
	import qdec_pkg::*;

	lane_state_e state_q;
	imem_addr_t  pc_q;
	// Instruction word and the word after it
	instr_t      w0_q;
	instr_t      w1_q;
	logic        is_halt;

	// Requests are held in the request states until the grant arrives
	assign mem.req  = (state_q == REQ0) || (state_q == REQ1);
	assign mem.addr = (state_q == REQ1) ? imem_addr_t'(pc_q + 1'b1) : pc_q;

	assign window_valid = (state_q == ISSUE);
	assign window_pc    = pc_q;
	assign window       = {w1_q, w0_q};

	assign is_halt = (w0_q.r.opcode == OP_HALT);

	// ================================================
	// Sequencer
	// ================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= IDLE;
			pc_q    <= start_pc;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					// The start address is tracked until the thread is released
					if (run)
					begin
						state_q <= REQ0;
					end
					else
					begin
						pc_q <= start_pc;
					end
				end
				REQ0:
				begin
					if (mem.gnt)
					begin
						state_q <= WAIT0;
					end
				end
				WAIT0:
				begin
					if (mem.rvalid)
					begin
						state_q <= REQ1;
					end
				end
				REQ1:
				begin
					if (mem.gnt)
					begin
						state_q <= WAIT1;
					end
				end
				WAIT1:
				begin
					if (mem.rvalid)
					begin
						state_q <= ISSUE;
					end
				end
				ISSUE:
				begin
					// Skip the postfix word when the decoder consumed it
					pc_q <= pc_q + (pfx_used ? imem_addr_t'(2) : imem_addr_t'(1));
					if (is_halt)
					begin
						state_q <= HALTED;
					end
					else if (run)
					begin
						state_q <= REQ0;
					end
					else
					begin
						state_q <= IDLE;
					end
				end
				HALTED:
				begin
					// Stay parked until the thread is stopped
					if (!run)
					begin
						state_q <= IDLE;
						pc_q    <= start_pc;
					end
				end
				default:
				begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// Each returned word lands in its window slot
	always_ff @(posedge clk)
	begin
		if ((state_q == WAIT0) && mem.rvalid)
		begin
			w0_q <= mem.rdata;
		end
		if ((state_q == WAIT1) && mem.rvalid)
		begin
			w1_q <= mem.rdata;
		end
	end

	// A wait state asks for nothing and always sees its word come back that cycle
	a_wait_handshake: assert property (@(posedge clk) disable iff (reset)
		((state_q == WAIT0) || (state_q == WAIT1)) |-> (!mem.req && mem.rvalid));

endmodule

//--- hdl/insn_decoder.sv
// ================================================
// Instruction decoder
// Turns a two word window into a registered
// decode bus with class flags and immediate
// ================================================

module insn_decoder (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   window_valid,
	input  qdec_pkg::imem_addr_t   window_pc,
	input  qdec_pkg::instr_t [1:0] window,
	output logic                   pfx_used,
	output logic                   dec_valid,
	output qdec_pkg::decode_bus_t  dec
);
	import qdec_pkg::*;

	instr_t           w0;
	instr_t           w1;
	// Operand format of word 0
	logic             reg_form;
	logic             imm_form;
	logic [IMM_W-1:0] imm_short;
	logic [IMM_W-1:0] imm_long;
	decode_bus_t      db;

	assign w0 = window[0];
	assign w1 = window[1];

	// ================================================
	// Immediate
	// ================================================

	// Plain sign extension of imm16
	assign imm_short = {{(IMM_W - 16){w0.i.imm16[15]}}, w0.i.imm16};
	// Postfix supplies bits 41..16 and the sign comes from its top payload bit
	assign imm_long  = {{(IMM_W - 42){w1.p.payload[25]}}, w1.p.payload, w0.i.imm16};

	// A postfix only counts when it follows an immediate form
	assign pfx_used = imm_form && (w1.p.opcode == OP_PFX);

	// ================================================
	// Field and class decode
	// ================================================

	always_comb
	begin
		db          = '0;
		db.pc       = window_pc;
		db.opcode   = OP_NOP;
		reg_form    = 1'b0;
		imm_form    = 1'b0;

		case (w0.r.opcode)
			OP_NOP:
			begin
				db.nop = 1'b1;
			end
			OP_ADD, OP_SUB:
			begin
				reg_form = 1'b1;
				db.alu   = 1'b1;
			end
			OP_ADDI:
			begin
				imm_form = 1'b1;
				db.alu   = 1'b1;
			end
			OP_MUL:
			begin
				reg_form = 1'b1;
				db.mul   = 1'b1;
			end
			OP_MULU:
			begin
				reg_form = 1'b1;
				db.mulu  = 1'b1;
			end
			OP_DIV:
			begin
				reg_form = 1'b1;
				db.div   = 1'b1;
			end
			OP_DIVU:
			begin
				reg_form = 1'b1;
				db.divu  = 1'b1;
			end
			OP_LOAD:
			begin
				imm_form = 1'b1;
				db.load  = 1'b1;
			end
			OP_LOADZ:
			begin
				imm_form = 1'b1;
				db.loadz = 1'b1;
			end
			OP_STORE:
			begin
				imm_form = 1'b1;
				db.store = 1'b1;
			end
			OP_LDA:
			begin
				// Address generation goes through the alu
				imm_form = 1'b1;
				db.lda   = 1'b1;
				db.alu   = 1'b1;
			end
			OP_BEQ, OP_BNE:
			begin
				imm_form  = 1'b1;
				db.branch = 1'b1;
			end
			OP_FENCE:
			begin
				db.fence = 1'b1;
			end
			OP_HALT:
			begin
				db.halt = 1'b1;
			end
			default:
			begin
				// Unknown codes and a postfix on its own become an illegal nop
				db.nop     = 1'b1;
				db.illegal = 1'b1;
			end
		endcase

		// Known codes keep their own opcode
		if (!db.illegal)
		begin
			db.opcode = opcode_e'(w0.r.opcode);
		end

		// Register fields by format
		if (reg_form || imm_form)
		begin
			db.rt = w0.r.rt;
			db.ra = w0.r.ra;
		end
		if (reg_form)
		begin
			db.rb = w0.r.rb;
			db.rc = w0.r.rc;
		end

		if (imm_form)
		begin
			db.has_imm  = 1'b1;
			db.pfx_used = (w1.p.opcode == OP_PFX);
			db.imm      = db.pfx_used ? imm_long : imm_short;
		end

		// Backward branch follows the sign of the final displacement
		db.backbr = db.branch && db.imm[IMM_W-1];
	end

	// ================================================
	// Output register
	// ================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dec_valid <= 1'b0;
		end
		else
		begin
			dec_valid <= window_valid;
		end
	end

	// The bus itself is payload and only loads on a window
	always_ff @(posedge clk)
	begin
		if (window_valid)
		begin
			dec <= db;
		end
	end

	// A postfix word never reaches the consumer as an instruction
	a_no_pfx_primary: assert property (@(posedge clk) disable iff (reset)
		dec_valid |-> (dec.opcode != OP_PFX));

endmodule

//--- hdl/decode_unit_top.sv
// ================================================
// Decode front end top level
// Shared memory, arbiter, two lanes and decoders
// ================================================

module decode_unit_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  run_a,
	input  logic                  run_b,
	input  qdec_pkg::imem_addr_t  start_pc_a,
	input  qdec_pkg::imem_addr_t  start_pc_b,
	input  logic                  wr_en,
	input  qdec_pkg::imem_addr_t  wr_addr,
	input  qdec_pkg::instr_t      wr_data,
	output logic                  dec_valid_a,
	output qdec_pkg::decode_bus_t dec_a,
	output logic                  dec_valid_b,
	output qdec_pkg::decode_bus_t dec_b
);
	import qdec_pkg::*;

	// Memory port between arbiter and RAM
	logic       mem_en;
	logic       mem_we;
	imem_addr_t mem_addr;
	instr_t     mem_wdata;
	instr_t     mem_rdata;

	// Lane to decoder windows and the postfix return path
	logic         win_valid_a;
	logic         win_valid_b;
	imem_addr_t   win_pc_a;
	imem_addr_t   win_pc_b;
	instr_t [1:0] window_a;
	instr_t [1:0] window_b;
	logic         pfx_used_a;
	logic         pfx_used_b;

	imem_if lane_a_if ();
	imem_if lane_b_if ();
	imem_if load_if ();

	// The write port is a requester that is always granted when it asks
	assign load_if.req  = wr_en;
	assign load_if.addr = wr_addr;

	insn_mem u_insn_mem (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	imem_arbiter u_imem_arbiter (
		.clk       (clk),
		.reset     (reset),
		.lane_a    (lane_a_if.arbiter),
		.lane_b    (lane_b_if.arbiter),
		.load      (load_if.arbiter),
		.wr_data   (wr_data),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	// ================================================
	// Thread A
	// ================================================

	fetch_lane u_fetch_lane_a (
		.clk          (clk),
		.reset        (reset),
		.run          (run_a),
		.start_pc     (start_pc_a),
		.mem          (lane_a_if.requester),
		.window_valid (win_valid_a),
		.window_pc    (win_pc_a),
		.window       (window_a),
		.pfx_used     (pfx_used_a)
	);

	insn_decoder u_insn_decoder_a (
		.clk          (clk),
		.reset        (reset),
		.window_valid (win_valid_a),
		.window_pc    (win_pc_a),
		.window       (window_a),
		.pfx_used     (pfx_used_a),
		.dec_valid    (dec_valid_a),
		.dec          (dec_a)
	);

	// ================================================
	// Thread B
	// ================================================

	fetch_lane u_fetch_lane_b (
		.clk          (clk),
		.reset        (reset),
		.run          (run_b),
		.start_pc     (start_pc_b),
		.mem          (lane_b_if.requester),
		.window_valid (win_valid_b),
		.window_pc    (win_pc_b),
		.window       (window_b),
		.pfx_used     (pfx_used_b)
	);

	insn_decoder u_insn_decoder_b (
		.clk          (clk),
		.reset        (reset),
		.window_valid (win_valid_b),
		.window_pc    (win_pc_b),
		.window       (window_b),
		.pfx_used     (pfx_used_b),
		.dec_valid    (dec_valid_b),
		.dec          (dec_b)
	);

endmodule

//--- dv/tb_decode_unit.sv
// ================================================
// Decode front end testbench
// Loads program images, runs both lanes and checks
// every decode pulse against a reference decode
// ================================================

module tb_decode_unit;
	import qdec_pkg::*;

	// One word of a program image at its address
	typedef struct packed {
		imem_addr_t  addr;
		logic [31:0] word;
	} image_entry_t;

	logic        clk;
	logic        reset;
	logic        run_a;
	logic        run_b;
	imem_addr_t  start_pc_a;
	imem_addr_t  start_pc_b;
	logic        wr_en;
	imem_addr_t  wr_addr;
	instr_t      wr_data;
	logic        dec_valid_a;
	decode_bus_t dec_a;
	logic        dec_valid_b;
	decode_bus_t dec_b;

	int           seed;
	// Testbench copy of what the memory should hold
	logic [31:0]  image [IMEM_DEPTH];
	// Words loaded before any run, and words written while the lanes run
	image_entry_t prog_tbl[$];
	image_entry_t late_tbl[$];
	// Decodes still owed by each lane, oldest first
	decode_bus_t  exp_a[$];
	decode_bus_t  exp_b[$];

	decode_unit_top u_decode_unit_top (
		.clk         (clk),
		.reset       (reset),
		.run_a       (run_a),
		.run_b       (run_b),
		.start_pc_a  (start_pc_a),
		.start_pc_b  (start_pc_b),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.dec_valid_a (dec_valid_a),
		.dec_a       (dec_a),
		.dec_valid_b (dec_valid_b),
		.dec_b       (dec_b)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ================================================
	// Failure reporting and compares
	// ================================================

	task automatic stop_on_error();
		$display("CHECKS FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_pc(input string name, input imem_addr_t got, input imem_addr_t want);
		if (got !== want)
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_decode(input string name, input decode_bus_t got,
			input decode_bus_t want);
		if (got !== want)
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	// ================================================
	// Reference decode
	// ================================================

	// Built straight from the instruction set rules, one window at a time
	function automatic decode_bus_t ref_decode(input imem_addr_t pc, input logic [31:0] w0,
			input logic [31:0] w1);
		logic [5:0]         op;
		logic               known;
		logic               reg_form;
		logic               imm_form;
		logic signed [31:0] pfx_ext;
		decode_bus_t        d;
		op       = w0[31:26];
		d        = '0;
		d.pc     = pc;
		// A postfix word on its own is not an instruction
		known    = op inside {OP_NOP, OP_ADD, OP_SUB, OP_ADDI, OP_MUL, OP_MULU, OP_DIV,
			OP_DIVU, OP_LOAD, OP_LOADZ, OP_STORE, OP_LDA, OP_BEQ, OP_BNE, OP_FENCE, OP_HALT};
		reg_form = op inside {OP_ADD, OP_SUB, OP_MUL, OP_MULU, OP_DIV, OP_DIVU};
		imm_form = op inside {OP_ADDI, OP_LOAD, OP_LOADZ, OP_STORE, OP_LDA, OP_BEQ, OP_BNE};
		d.opcode  = known ? opcode_e'(op) : OP_NOP;
		d.illegal = !known;
		d.nop     = (op == OP_NOP) || !known;
		d.alu     = op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LDA};
		d.mul     = (op == OP_MUL);
		d.mulu    = (op == OP_MULU);
		d.div     = (op == OP_DIV);
		d.divu    = (op == OP_DIVU);
		d.load    = (op == OP_LOAD);
		d.loadz   = (op == OP_LOADZ);
		d.store   = (op == OP_STORE);
		d.lda     = (op == OP_LDA);
		d.branch  = op inside {OP_BEQ, OP_BNE};
		d.fence   = (op == OP_FENCE);
		d.halt    = (op == OP_HALT);
		if (reg_form || imm_form)
		begin
			d.rt = w0[25:21];
			d.ra = w0[20:16];
		end
		if (reg_form)
		begin
			d.rb = w0[15:11];
			d.rc = w0[10:6];
		end
		if (imm_form)
		begin
			d.has_imm  = 1'b1;
			d.pfx_used = (w1[31:26] == OP_PFX);
			if (d.pfx_used)
			begin
				// Postfix payload is the signed upper part above imm16
				pfx_ext = 32'($signed(w1[25:0]));
				d.imm   = {pfx_ext, w0[15:0]};
			end
			else
			begin
				d.imm = 48'($signed(w0[15:0]));
			end
		end
		d.backbr = d.branch && d.imm[47];
		return d;
	endfunction

	// Walks a program from its start and queues the decodes it must produce
	task automatic expect_program(input bit on_b, input imem_addr_t start);
		imem_addr_t  pc;
		decode_bus_t d;
		pc = start;
		for (int steps = 0; steps < 64; steps++)
		begin
			d = ref_decode(pc, image[pc], image[imem_addr_t'(pc + 1)]);
			if (on_b)
			begin
				exp_b.push_back(d);
			end
			else
			begin
				exp_a.push_back(d);
			end
			if (d.halt)
			begin
				break;
			end
			pc = imem_addr_t'(pc + (d.pfx_used ? 2 : 1));
		end
	endtask

	// ================================================
	// Program table
	// ================================================

	// Register fields and unused bits are random
	function automatic logic [31:0] reg_word(input opcode_e op);
		return {op, 26'($random(seed))};
	endfunction

	function automatic logic [31:0] imm_word(input opcode_e op, input logic [15:0] imm16);
		return {op, 10'($random(seed)), imm16};
	endfunction

	function automatic logic [31:0] pfx_word(input logic [25:0] payload);
		return {OP_PFX, payload};
	endfunction

	// Nop words that still tell every address apart
	function automatic logic [31:0] fill_word(input imem_addr_t a);
		return {OP_NOP, 2'b10, a, ~a, a};
	endfunction

	function automatic logic [31:0] late_fill(input imem_addr_t a);
		return {OP_NOP, 2'b01, ~a, a, ~a};
	endfunction

	task automatic add_entry(input bit late, input imem_addr_t addr, input logic [31:0] word);
		image_entry_t e;
		e.addr = addr;
		e.word = word;
		if (late)
		begin
			late_tbl.push_back(e);
		end
		else
		begin
			prog_tbl.push_back(e);
		end
	endtask

	task automatic build_programs();
		// Program A at 0x10, every class plus postfix cases
		add_entry(0, 8'h10, reg_word(OP_ADD));
		add_entry(0, 8'h11, reg_word(OP_SUB));
		add_entry(0, 8'h12, imm_word(OP_ADDI, 16'h1234));
		add_entry(0, 8'h13, reg_word(OP_MUL));
		add_entry(0, 8'h14, reg_word(OP_MULU));
		add_entry(0, 8'h15, reg_word(OP_DIV));
		add_entry(0, 8'h16, reg_word(OP_DIVU));
		add_entry(0, 8'h17, imm_word(OP_LOAD, 16'hfff0));
		add_entry(0, 8'h18, imm_word(OP_LOADZ, 16'h0040));
		add_entry(0, 8'h19, imm_word(OP_STORE, 16'h8001));
		add_entry(0, 8'h1a, imm_word(OP_LDA, 16'h7fff));
		add_entry(0, 8'h1b, reg_word(OP_FENCE));
		add_entry(0, 8'h1c, reg_word(OP_NOP));
		add_entry(0, 8'h1d, {6'h2a, 26'($random(seed))});
		add_entry(0, 8'h1e, imm_word(OP_ADDI, 16'h00ff));
		add_entry(0, 8'h1f, pfx_word(26'h0000123));
		add_entry(0, 8'h20, imm_word(OP_LOAD, 16'h8000));
		add_entry(0, 8'h21, pfx_word(26'h3ffff00));
		// Postfix after a register form stands alone
		add_entry(0, 8'h22, reg_word(OP_ADD));
		add_entry(0, 8'h23, pfx_word(26'h0015555));
		add_entry(0, 8'h24, reg_word(OP_HALT));
		// Program B at 0x60, branches both ways
		add_entry(0, 8'h60, imm_word(OP_BEQ, 16'h0008));
		add_entry(0, 8'h61, imm_word(OP_BNE, 16'hfffc));
		add_entry(0, 8'h62, imm_word(OP_BEQ, 16'h8000));
		add_entry(0, 8'h63, imm_word(OP_BNE, 16'h0100));
		add_entry(0, 8'h64, imm_word(OP_STORE, 16'h0010));
		add_entry(0, 8'h65, pfx_word(26'h2000000));
		// Postfix of all ones turns a small displacement backward
		add_entry(0, 8'h66, imm_word(OP_BEQ, 16'h0004));
		add_entry(0, 8'h67, pfx_word(26'h3ffffff));
		add_entry(0, 8'h68, reg_word(OP_SUB));
		add_entry(0, 8'h69, reg_word(OP_HALT));
		// Program C at 0xc0 only exists after the writes during the shared run
		add_entry(1, 8'hc0, imm_word(OP_LDA, 16'h0abc));
		add_entry(1, 8'hc1, pfx_word(26'h0000001));
		add_entry(1, 8'hc2, reg_word(OP_MULU));
		add_entry(1, 8'hc3, imm_word(OP_BNE, 16'hff00));
		add_entry(1, 8'hc4, reg_word(OP_HALT));
		for (int i = 8'hc5; i < 8'hdc; i++)
		begin
			add_entry(1, imem_addr_t'(i), late_fill(imem_addr_t'(i)));
		end
	endtask

	// ================================================
	// Drivers
	// ================================================

	task automatic write_word(input imem_addr_t addr, input logic [31:0] word);
		@(posedge clk);
		#1;
		wr_en       = 1'b1;
		wr_addr     = addr;
		wr_data     = instr_t'(word);
		image[addr] = word;
	endtask

	task automatic release_write_port();
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	task automatic stream_late_writes();
		foreach (late_tbl[k])
		begin
			write_word(late_tbl[k].addr, late_tbl[k].word);
		end
		release_write_port();
	endtask

	// Start addresses go in a cycle ahead so the idle lanes pick them up
	task automatic start_lanes(input logic go_a, input imem_addr_t pc_a, input logic go_b,
			input imem_addr_t pc_b);
		@(posedge clk);
		#1;
		start_pc_a = pc_a;
		start_pc_b = pc_b;
		@(posedge clk);
		#1;
		run_a = go_a;
		run_b = go_b;
	endtask

	task automatic stop_lanes();
		@(posedge clk);
		#1;
		run_a = 1'b0;
		run_b = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic wait_for_decodes(input int limit);
		int cycles;
		cycles = 0;
		while ((exp_a.size() != 0) || (exp_b.size() != 0))
		begin
			@(posedge clk);
			cycles++;
			if (cycles > limit)
			begin
				$display("Timeout after %0d cycles: lane A still owes %0d decodes, lane B %0d",
					limit, exp_a.size(), exp_b.size());
				stop_on_error();
			end
		end
	endtask

	// ================================================
	// Decode monitors
	// ================================================

	task automatic match_decode(input bit on_b, input decode_bus_t got);
		decode_bus_t want;
		string       name;
		name = on_b ? "dec_b" : "dec_a";
		if ((on_b && (exp_b.size() == 0)) || (!on_b && (exp_a.size() == 0)))
		begin
			$display("Unexpected decode on %s at %0t with pc %h", name, $time, got.pc);
			stop_on_error();
		end
		else
		begin
			if (on_b)
			begin
				want = exp_b.pop_front();
			end
			else
			begin
				want = exp_a.pop_front();
			end
			check_pc({name, ".pc"}, got.pc, want.pc);
			check_decode(name, got, want);
		end
	endtask

	// Registered outputs are read mid cycle
	always @(negedge clk)
	begin
		if (!reset && (dec_valid_a === 1'b1))
		begin
			match_decode(1'b0, dec_a);
		end
	end

	always @(negedge clk)
	begin
		if (!reset && (dec_valid_b === 1'b1))
		begin
			match_decode(1'b1, dec_b);
		end
	end

	// ================================================
	// Sequence
	// ================================================

	initial
	begin
		seed       = 73889;
		reset      = 1'b1;
		run_a      = 1'b0;
		run_b      = 1'b0;
		start_pc_a = '0;
		start_pc_b = '0;
		wr_en      = 1'b0;
		wr_addr    = '0;
		wr_data    = '0;
		build_programs();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// Whole memory gets the fill, then programs A and B on top
		for (int i = 0; i < IMEM_DEPTH; i++)
		begin
			image[imem_addr_t'(i)] = fill_word(imem_addr_t'(i));
		end
		foreach (prog_tbl[k])
		begin
			image[prog_tbl[k].addr] = prog_tbl[k].word;
		end
		for (int i = 0; i < IMEM_DEPTH; i++)
		begin
			write_word(imem_addr_t'(i), image[imem_addr_t'(i)]);
			@(negedge clk);
			check_flag("dec_valid_a", dec_valid_a, 1'b0);
			check_flag("dec_valid_b", dec_valid_b, 1'b0);
		end
		release_write_port();

		// Lane A alone
		expect_program(1'b0, 8'h10);
		start_lanes(1'b1, 8'h10, 1'b0, 8'h00);
		wait_for_decodes(600);
		stop_lanes();

		// Both lanes share the port while a write burst stalls them
		expect_program(1'b0, 8'h10);
		expect_program(1'b1, 8'h60);
		start_lanes(1'b1, 8'h10, 1'b1, 8'h60);
		fork
			stream_late_writes();
			wait_for_decodes(800);
		join
		stop_lanes();

		// The rewritten region now holds program C
		expect_program(1'b0, 8'hc0);
		start_lanes(1'b1, 8'hc0, 1'b0, 8'h00);
		wait_for_decodes(600);
		stop_lanes();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- build.f
hdl/qdec_pkg.sv
hdl/imem_if.sv
hdl/insn_mem.sv
hdl/imem_arbiter.sv
hdl/fetch_lane.sv
hdl/insn_decoder.sv
hdl/decode_unit_top.sv
dv/tb_decode_unit.sv

//--- Makefile
# Verilator flow for the decode front end testbench

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_decode_unit
FILELIST   = build.f
BIN        = obj_dir/V$(TOP)
PASS_MSG   = ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
